//--- filelist.f
common/mm_pkg.sv
dma/operand_buffer.sv
dma/dma_engine.sv
mm/mm_engine.sv
rtl/mm_accel_top.sv
tests/tb_clock_gen.sv
tests/mm_accel_assertions.sv
tests/tb_mm_accel.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the accelerator testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_mm_accel -f filelist.f -Mdir obj_dir
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/Vtb_mm_accel)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "Test completed successfully"; then
    exit 0
else
    exit 1
fi

//--- tests/tb_mm_accel.sv
// testbench for the matrix-multiply accelerator
// word-addressed AXI memory model, table of runs, signed reference for C
// all DUT inputs change on the falling clock edge

`timescale 1ns/1ps

module tb_mm_accel;

    import mm_pkg::*;

    localparam int NUM_TESTS      = 4;
    localparam int TIMEOUT_CYCLES = NUM_TESTS * 400 + 20;

    // one run with base addresses, A transposed, B and a back-pressure flag
    typedef struct packed {
        addr_t         a_addr;
        addr_t         b_addr;
        addr_t         c_addr;
        data_t [0:3]   at;
        data_t [0:3]   b;
        logic          bp;
    } test_t;

    logic     clk;
    logic     rst_n;
    logic     start;
    addr_t    a_addr;
    addr_t    b_addr;
    addr_t    c_addr;
    logic     done;
    axi_ar_t  ar;
    logic     ar_ready;
    axi_r_t   r_drv;
    logic     r_ready;
    axi_aw_t  aw;
    logic     aw_ready;
    axi_w_t   w;
    logic     w_ready;
    axi_b_t   b_drv;
    logic     b_ready;

    test_t    tests [NUM_TESTS];
    data_t    mem [256];

    // memory model state
    int       rd_ptr [2];
    int       rd_left [2];
    logic     r_fire;
    logic     b_fire;
    logic     b_pend;
    logic     b_done;
    int       c_ptr;
    int       w_cnt;
    int       ar_cnt;
    int       done_cnt;
    logic     bp;

    logic [15:0] lfsr;
    int       test_errs;
    int       err_count;
    int       cycles = 0;

    tb_clock_gen clk_gen (
        .clk_o   (clk),
        .rst_n_o (rst_n)
    );

    mm_accel_top dut_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .start_i      (start),
        .mat_a_addr_i (a_addr),
        .mat_b_addr_i (b_addr),
        .mat_c_addr_i (c_addr),
        .done_o       (done),
        .ar_o         (ar),
        .ar_ready_i   (ar_ready),
        .r_i          (r_drv),
        .r_ready_o    (r_ready),
        .aw_o         (aw),
        .aw_ready_i   (aw_ready),
        .w_o          (w),
        .w_ready_i    (w_ready),
        .b_i          (b_drv),
        .b_ready_o    (b_ready)
    );

    // galois lfsr over taps 16 14 13 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    // one pseudo-random bit per lfsr step
    function automatic logic rand_bit();
        logic bit_out;
        bit_out = lfsr[0];
        lfsr    = lfsr_step(lfsr);
        return bit_out;
    endfunction

    // C[i][j] = sum_k A[i][k] * B[k][j]
    // A[i][k] sits in byte i of column word k
    function automatic int ref_elem(input test_t t, input int i, input int j);
        int sum;
        int a;
        int b;
        sum = 0;
        for (int k = 0; k < 4; k++) begin
            a   = elem_t'(t.at[k][8*i +: 8]);
            b   = elem_t'(t.b[k][8*j +: 8]);
            sum = sum + a * b;
        end
        return sum;
    endfunction

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("Fail %s: expected 0x%08h, got 0x%08h", name, exp, act);
            test_errs++;
        end
    endtask

    // background pattern from the word index and then the operands
    task automatic load_memory(input test_t t);
        logic [7:0] idx;
        for (int n = 0; n < 256; n++) begin
            idx    = n[7:0];
            mem[n] = {idx ^ 8'hA5, idx, ~idx, idx ^ 8'h3C};
        end
        for (int k = 0; k < 4; k++) begin
            mem[int'(t.a_addr[9:2]) + k] = t.at[k];
            mem[int'(t.b_addr[9:2]) + k] = t.b[k];
        end
    endtask

    // memory model called once per falling edge
    // a fire decided here completes on the next rising edge
    task automatic service_bus();
        logic sel;
        logic gap;
        // write response only after the last W has gone
        if (b_fire) begin
            b_drv  = '0;
            b_pend = 1'b0;
        end
        if (b_pend && !b_drv.valid) begin
            gap = bp && rand_bit();
            if (!gap) begin
                b_drv.valid = 1'b1;
                b_drv.resp  = 2'b00;
            end
        end
        b_fire = b_drv.valid && b_ready;
        if (b_fire) begin
            b_done = 1'b1;
        end
        // read beats with ids mixed at random while both bursts are open
        if (r_fire) begin
            r_drv = '0;
        end
        if (!r_drv.valid && (rd_left[0] > 0 || rd_left[1] > 0)) begin
            gap = bp && rand_bit();
            if (rd_left[0] > 0 && rd_left[1] > 0) begin
                sel = rand_bit();
            end else begin
                sel = (rd_left[1] > 0);
            end
            if (!gap) begin
                r_drv.valid = 1'b1;
                r_drv.id    = sel;
                r_drv.data  = mem[rd_ptr[sel]];
                r_drv.last  = (rd_left[sel] == 1);
            end
        end
        r_fire = r_drv.valid && r_ready;
        if (r_fire) begin
            rd_ptr[r_drv.id]  = rd_ptr[r_drv.id] + 1;
            rd_left[r_drv.id] = rd_left[r_drv.id] - 1;
        end
        // read requests come A first then B
        ar_ready = !bp || rand_bit();
        if (ar.valid && ar_ready) begin
            check("arid", (ar_cnt == 0) ? 32'd0 : 32'd1, 32'(ar.id));
            check("araddr", (ar_cnt == 0) ? a_addr : b_addr, ar.addr);
            check("arlen", 32'd3, 32'(ar.len));
            check("arsize", 32'd2, 32'(ar.size));
            check("arburst", 32'd1, 32'(ar.burst));
            rd_ptr[ar.id]  = int'(ar.addr[9:2]);
            rd_left[ar.id] = int'(ar.len) + 1;
            ar_cnt++;
        end
        // result burst
        aw_ready = !bp || rand_bit();
        if (aw.valid && aw_ready) begin
            check("awaddr", c_addr, aw.addr);
            check("awlen", 32'd15, 32'(aw.len));
            check("awsize", 32'd2, 32'(aw.size));
            check("awburst", 32'd1, 32'(aw.burst));
            c_ptr = int'(aw.addr[9:2]);
            w_cnt = 0;
        end
        w_ready = !bp || rand_bit();
        if (w.valid && w_ready) begin
            check("wstrb", 32'hF, 32'(w.strb));
            check("wlast", 32'(w_cnt == 15), 32'(w.last));
            mem[(c_ptr + w_cnt) % 256] = w.data;
            if (w.last) begin
                b_pend = 1'b1;
            end
            w_cnt++;
        end
    endtask

    task automatic step_bus();
        service_bus();
        if (done) begin
            done_cnt++;
            if (!b_done) begin
                $display("done_o rose before the write response was accepted");
                test_errs++;
            end
        end
    endtask

    // run limit
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == TIMEOUT_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Test failed");
            $finish;
        end
    end

    initial begin
        int cyc;
        int c_idx;
        start     = 1'b0;
        a_addr    = '0;
        b_addr    = '0;
        c_addr    = '0;
        ar_ready  = 1'b0;
        aw_ready  = 1'b0;
        w_ready   = 1'b0;
        r_drv     = '0;
        b_drv     = '0;
        bp        = 1'b0;
        lfsr      = 16'd73;
        err_count = 0;

        // identity A, then extremes, then stalls, then a second stalled run
        tests[0] = '{a_addr: 32'h000, b_addr: 32'h040, c_addr: 32'h100,
            at: '{32'h0000_0001, 32'h0000_0100, 32'h0001_0000, 32'h0100_0000},
            b:  '{32'h04FD_02FF, 32'h807F_10F0, 32'h0A0B_0C0D, 32'hFFEE_DDCC}, bp: 1'b0};
        tests[1] = '{a_addr: 32'h080, b_addr: 32'h0C0, c_addr: 32'h200,
            at: '{32'h807F_807F, 32'h7F80_7F80, 32'h8080_8080, 32'h7F7F_7F7F},
            b:  '{32'h807F_7F80, 32'h8080_7F7F, 32'h7F80_8080, 32'h7F7F_8080}, bp: 1'b0};
        tests[2] = '{a_addr: 32'h010, b_addr: 32'h020, c_addr: 32'h300,
            at: '{32'h12F3_A507, 32'hC439_1E88, 32'h5A6B_7C8D, 32'hE0D0_C0B0},
            b:  '{32'h0102_FEFD, 32'h33CC_55AA, 32'h7F80_017F, 32'h9A0B_8C7D}, bp: 1'b1};
        tests[3] = '{a_addr: 32'h3C0, b_addr: 32'h050, c_addr: 32'h140,
            at: '{32'hFFFE_FDFC, 32'h0304_0506, 32'h8001_7FFE, 32'h2468_ACE0},
            b:  '{32'h1357_9BDF, 32'hF0E1_D2C3, 32'h0000_0000, 32'h7F7F_8080}, bp: 1'b1};

        wait (rst_n);
        @(negedge clk);
        for (int ts = 0; ts < NUM_TESTS; ts++) begin
            load_memory(tests[ts]);
            a_addr    = tests[ts].a_addr;
            b_addr    = tests[ts].b_addr;
            c_addr    = tests[ts].c_addr;
            bp        = tests[ts].bp;
            rd_left   = '{0, 0};
            r_fire    = 1'b0;
            b_fire    = 1'b0;
            b_pend    = 1'b0;
            b_done    = 1'b0;
            ar_cnt    = 0;
            done_cnt  = 0;
            w_cnt     = 0;
            test_errs = 0;
            start     = 1'b1;
            cyc       = 0;
            while (done_cnt == 0) begin
                @(negedge clk);
                // stray start mid-run must not issue another AR
                start = (cyc == 6);
                step_bus();
                cyc++;
            end
            // watch for a second done pulse
            repeat (3) begin
                @(negedge clk);
                step_bus();
            end
            if (done_cnt != 1) begin
                $display("done_o pulsed %0d times in one run", done_cnt);
                test_errs++;
            end
            if (ar_cnt != 2) begin
                $display("expected 2 read bursts, saw %0d", ar_cnt);
                test_errs++;
            end
            c_idx = int'(tests[ts].c_addr[9:2]);
            for (int i = 0; i < 4; i++) begin
                for (int j = 0; j < 4; j++) begin
                    check($sformatf("c[%0d][%0d]", i, j), 32'(ref_elem(tests[ts], i, j)),
                        mem[c_idx + i*4 + j]);
                end
            end
            $display("test %0d: %0d errors", ts, test_errs);
            err_count = err_count + test_errs;
        end

        $display("%0d tests run, %0d errors", NUM_TESTS, err_count);
        if (err_count == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- tests/mm_accel_assertions.sv
// AXI master handshake and engine timing checks for the accelerator
// bound into mm_accel_top

`timescale 1ns/1ps

module mm_accel_assertions (
    input logic            clk,
    input logic            rst_n,
    input mm_pkg::axi_ar_t ar_i,
    input logic            ar_ready_i,
    input mm_pkg::axi_aw_t aw_i,
    input logic            aw_ready_i,
    input mm_pkg::axi_w_t  w_i,
    input logic            w_ready_i,
    input logic            mm_start_i,
    input logic            mm_done_i
);

    // a stalled valid stays up until ready
    ar_valid_held: assert property (@(posedge clk) disable iff (!rst_n)
        ar_i.valid && !ar_ready_i |=> ar_i.valid)
        else $error("AR valid dropped without ready");
    aw_valid_held: assert property (@(posedge clk) disable iff (!rst_n)
        aw_i.valid && !aw_ready_i |=> aw_i.valid)
        else $error("AW valid dropped without ready");
    w_valid_held: assert property (@(posedge clk) disable iff (!rst_n)
        w_i.valid && !w_ready_i |=> w_i.valid)
        else $error("W valid dropped without ready");

    // payload frozen while stalled
    ar_stable: assert property (@(posedge clk) disable iff (!rst_n)
        ar_i.valid && !ar_ready_i |=> $stable(ar_i))
        else $error("AR payload changed while stalled");
    aw_stable: assert property (@(posedge clk) disable iff (!rst_n)
        aw_i.valid && !aw_ready_i |=> $stable(aw_i))
        else $error("AW payload changed while stalled");
    w_stable: assert property (@(posedge clk) disable iff (!rst_n)
        w_i.valid && !w_ready_i |=> $stable(w_i))
        else $error("W payload changed while stalled");

    // engine done exactly five cycles after its start and never otherwise
    mm_latency: assert property (@(posedge clk) disable iff (!rst_n)
        mm_done_i == $past(mm_start_i, 5))
        else $error("mm_done not five cycles after mm_start");

endmodule

bind mm_accel_top mm_accel_assertions axi_chk (
    .clk        (clk),
    .rst_n      (rst_n),
    .ar_i       (ar_o),
    .ar_ready_i (ar_ready_i),
    .aw_i       (aw_o),
    .aw_ready_i (aw_ready_i),
    .w_i        (w_o),
    .w_ready_i  (w_ready_i),
    .mm_start_i (mm_start),
    .mm_done_i  (mm_done)
);

//--- tests/tb_clock_gen.sv
// clock and reset source for the accelerator testbench
// 100 ns period, rst_n held low for the first 10 rising edges

`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk_o,
    output logic rst_n_o
);

    initial begin
        clk_o   = 1'b0;
        rst_n_o = 1'b0;
        repeat (10) @(posedge clk_o);
        // release away from the sampling edge
        @(negedge clk_o);
        rst_n_o = 1'b1;
    end

    always #50 clk_o = ~clk_o;

endmodule

//--- rtl/mm_accel_top.sv
// matrix-multiply accelerator top level
// joins the DMA engine, the A and B operand buffers and the MAC array;
// configuration by direct ports, memory through one AXI4 master

`timescale 1ns/1ps

module mm_accel_top (
    input  logic               clk,
    input  logic               rst_n,

    // run control
    input  logic               start_i,
    input  mm_pkg::addr_t      mat_a_addr_i,
    input  mm_pkg::addr_t      mat_b_addr_i,
    input  mm_pkg::addr_t      mat_c_addr_i,
    output logic               done_o,

    // AXI4 master
    output mm_pkg::axi_ar_t    ar_o,
    input  logic               ar_ready_i,
    input  mm_pkg::axi_r_t     r_i,
    output logic               r_ready_o,
    output mm_pkg::axi_aw_t    aw_o,
    input  logic               aw_ready_i,
    output mm_pkg::axi_w_t     w_o,
    input  logic               w_ready_i,
    input  mm_pkg::axi_b_t     b_i,
    output logic               b_ready_o
);

    import mm_pkg::*;

    // dma to buffers
    buf_wr_t  buf_a_wr;
    buf_wr_t  buf_b_wr;

    // engine row read, data back one cycle later
    row_idx_t rd_row;
    row_t     a_col;
    row_t     b_row;

    // engine handshake and result
    logic     mm_start;
    logic     mm_done;
    acc_mat_t result;

    dma_engine dma (
        .clk          (clk),
        .rst_n        (rst_n),
        .start_i      (start_i),
        .mat_a_addr_i (mat_a_addr_i),
        .mat_b_addr_i (mat_b_addr_i),
        .mat_c_addr_i (mat_c_addr_i),
        .done_o       (done_o),
        .ar_o         (ar_o),
        .ar_ready_i   (ar_ready_i),
        .r_i          (r_i),
        .r_ready_o    (r_ready_o),
        .aw_o         (aw_o),
        .aw_ready_i   (aw_ready_i),
        .w_o          (w_o),
        .w_ready_i    (w_ready_i),
        .b_i          (b_i),
        .b_ready_o    (b_ready_o),
        .buf_a_wr_o   (buf_a_wr),
        .buf_b_wr_o   (buf_b_wr),
        .mm_start_o   (mm_start),
        .mm_done_i    (mm_done),
        .result_i     (result)
    );

    // A stored transposed, one column per row
    operand_buffer buf_a (
        .clk       (clk),
        .rst_n     (rst_n),
        .wr_i      (buf_a_wr),
        .rd_row_i  (rd_row),
        .rd_data_o (a_col)
    );

    operand_buffer buf_b (
        .clk       (clk),
        .rst_n     (rst_n),
        .wr_i      (buf_b_wr),
        .rd_row_i  (rd_row),
        .rd_data_o (b_row)
    );

    mm_engine mm (
        .clk      (clk),
        .rst_n    (rst_n),
        .start_i  (mm_start),
        .rd_row_o (rd_row),
        .a_col_i  (a_col),
        .b_row_i  (b_row),
        .done_o   (mm_done),
        .result_o (result)
    );

endmodule

//--- mm/mm_engine.sv
// 4x4 signed multiply-accumulate array
// walks the operand buffers one row per cycle and sums outer products into C
// start_i is a one-cycle pulse; done_o pulses five cycles later

`timescale 1ns/1ps

module mm_engine (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               start_i,
    output mm_pkg::row_idx_t   rd_row_o,
    input  mm_pkg::row_t       a_col_i,
    input  mm_pkg::row_t       b_row_i,
    output logic               done_o,
    output mm_pkg::acc_mat_t   result_o
);

    import mm_pkg::*;

    // row being read from both buffers
    // sits at 0 while idle so row 0 is already on its way at start
    row_idx_t step_q;

    // high while buffer data is valid for accumulation
    logic     acc_en_q;
    // counts accumulate steps 0..3
    logic [1:0] acc_cnt_q;

    // unpacked operand elements for this step
    elem_t    a_elem [SA_WIDTH];
    elem_t    b_elem [SA_WIDTH];

    // products of the current step, sign extended
    acc_mat_t prod;

    // running sums, held as the result until the next start
    acc_mat_t acc_q;

    logic     start_ok;

    // ignore a start while already summing
    assign start_ok = start_i && !acc_en_q;
    assign rd_row_o = step_q;
    assign result_o = acc_q;

    // split packed rows into elements
    always_comb begin
        for (int k = 0; k < SA_WIDTH; k++) begin
            a_elem[k] = a_col_i[8*k +: 8];
            b_elem[k] = b_row_i[8*k +: 8];
        end
    end

    // outer product of A column and B row
    // A is stored transposed, so element i of a column is A[i][k]
    always_comb begin
        for (int i = 0; i < SA_WIDTH; i++) begin
            for (int j = 0; j < SA_WIDTH; j++) begin
                prod[i*SA_WIDTH+j] = acc_t'(a_elem[i]) * acc_t'(b_elem[j]);
            end
        end
    end

    // control: step counter, accumulate window, done pulse
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            step_q    <= '0;
            acc_en_q  <= 1'b0;
            acc_cnt_q <= '0;
            done_o    <= 1'b0;
        end else begin
            done_o <= 1'b0;
            // advance rows 1..3, then wrap back to 0 and park
            if (start_ok || step_q != '0) begin
                step_q <= step_q + 1'b1;
            end
            if (start_ok) begin
                acc_en_q  <= 1'b1;
                acc_cnt_q <= '0;
            end else if (acc_en_q) begin
                acc_cnt_q <= acc_cnt_q + 1'b1;
                // last row summed on this edge
                if (acc_cnt_q == 2'd3) begin
                    acc_en_q <= 1'b0;
                    done_o   <= 1'b1;
                end
            end
        end
    end

    // accumulators
    // clear on start, then one outer product per valid step
    always_ff @(posedge clk) begin
        if (start_ok) begin
            acc_q <= '0;
        end else if (acc_en_q) begin
            for (int n = 0; n < SA_WIDTH*SA_WIDTH; n++) begin
                acc_q[n] <= acc_q[n] + prod[n];
            end
        end
    end

endmodule

//--- dma/dma_engine.sv
// DMA control for the accelerator
// reads A^T and B with two AXI4 bursts (ids 0 and 1), fills both operand buffers,
// starts the matrix engine, then writes the 16-word result in one burst

`timescale 1ns/1ps

module dma_engine (
    input  logic               clk,
    input  logic               rst_n,

    // run control
    input  logic               start_i,
    input  mm_pkg::addr_t      mat_a_addr_i,
    input  mm_pkg::addr_t      mat_b_addr_i,
    input  mm_pkg::addr_t      mat_c_addr_i,
    output logic               done_o,

    // AXI4 master
    output mm_pkg::axi_ar_t    ar_o,
    input  logic               ar_ready_i,
    input  mm_pkg::axi_r_t     r_i,
    output logic               r_ready_o,
    output mm_pkg::axi_aw_t    aw_o,
    input  logic               aw_ready_i,
    output mm_pkg::axi_w_t     w_o,
    input  logic               w_ready_i,
    input  mm_pkg::axi_b_t     b_i,
    output logic               b_ready_o,

    // operand buffer writes
    output mm_pkg::buf_wr_t    buf_a_wr_o,
    output mm_pkg::buf_wr_t    buf_b_wr_o,

    // matrix engine
    output logic               mm_start_o,
    input  logic               mm_done_i,
    input  mm_pkg::acc_mat_t   result_i
);

    import mm_pkg::*;

    dma_state_e state_q;
    dma_state_e state_n;

    // rows landed per buffer, 0..4
    logic [2:0] cnt_a_q;
    logic [2:0] cnt_b_q;
    // write beat index, row-major into result_i
    logic [3:0] beat_q;

    // handshakes
    logic ar_hs;
    logic r_hs;
    logic aw_hs;
    logic w_hs;
    logic b_hs;

    // both buffers full
    logic load_done;
    logic last_beat;

    assign ar_hs = ar_o.valid && ar_ready_i;
    assign r_hs  = r_i.valid && r_ready_o;
    assign aw_hs = aw_o.valid && aw_ready_i;
    assign w_hs  = w_o.valid && w_ready_i;
    assign b_hs  = b_i.valid && b_ready_o;

    assign load_done = (cnt_a_q == 3'(SA_WIDTH)) && (cnt_b_q == 3'(SA_WIDTH));
    assign last_beat = ({4'd0, beat_q} == BURST_LEN_C);

    // next state
    always_comb begin
        state_n = state_q;
        case (state_q)
            IDLE:    if (start_i) state_n = REQ_A;
            REQ_A:   if (ar_hs) state_n = REQ_B;
            REQ_B:   if (ar_hs) state_n = LOAD;
            LOAD:    if (load_done) state_n = COMPUTE;
            COMPUTE: if (mm_done_i) state_n = REQ_C;
            REQ_C:   if (aw_hs) state_n = WRITE_C;
            WRITE_C: if (w_hs && last_beat) state_n = RESP_C;
            RESP_C:  if (b_hs) state_n = IDLE;
            default: state_n = IDLE;
        endcase
    end

    // read address, one request per state
    always_comb begin
        ar_o       = '0;
        ar_o.valid = (state_q == REQ_A) || (state_q == REQ_B);
        ar_o.id    = (state_q == REQ_B) ? ID_B : ID_A;
        ar_o.addr  = (state_q == REQ_B) ? mat_b_addr_i : mat_a_addr_i;
        ar_o.len   = BURST_LEN_AB;
        ar_o.size  = AXI_SIZE_4B;
        ar_o.burst = AXI_BURST_INCR;
    end

    // beats may interleave, only accepted during LOAD
    assign r_ready_o = (state_q == LOAD);

    // steer each beat by RID into the next free row of its buffer
    always_comb begin
        buf_a_wr_o      = '0;
        buf_a_wr_o.en   = r_hs && (r_i.id == ID_A);
        buf_a_wr_o.row  = cnt_a_q[1:0];
        buf_a_wr_o.data = r_i.data;
        buf_b_wr_o      = '0;
        buf_b_wr_o.en   = r_hs && (r_i.id == ID_B);
        buf_b_wr_o.row  = cnt_b_q[1:0];
        buf_b_wr_o.data = r_i.data;
    end

    // one cycle, the cycle after the last beat lands
    assign mm_start_o = (state_q == LOAD) && load_done;

    // result write address
    always_comb begin
        aw_o       = '0;
        aw_o.valid = (state_q == REQ_C);
        aw_o.addr  = mat_c_addr_i;
        aw_o.len   = BURST_LEN_C;
        aw_o.size  = AXI_SIZE_4B;
        aw_o.burst = AXI_BURST_INCR;
    end

    // result beats, C[i][j] at beat i*4+j
    always_comb begin
        w_o       = '0;
        w_o.valid = (state_q == WRITE_C);
        w_o.data  = data_t'(result_i[beat_q]);
        w_o.strb  = '1;
        w_o.last  = last_beat;
    end

    assign b_ready_o = (state_q == RESP_C);

    // state, counters and done pulse
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= IDLE;
            cnt_a_q <= '0;
            cnt_b_q <= '0;
            beat_q  <= '0;
            done_o  <= 1'b0;
        end else begin
            state_q <= state_n;
            // high the cycle after B
            done_o  <= b_hs;
            if (state_q == IDLE && start_i) begin
                cnt_a_q <= '0;
                cnt_b_q <= '0;
                beat_q  <= '0;
            end
            if (buf_a_wr_o.en) begin
                cnt_a_q <= cnt_a_q + 1'b1;
            end
            if (buf_b_wr_o.en) begin
                cnt_b_q <= cnt_b_q + 1'b1;
            end
            // moves only on accepted beats
            if (w_hs) begin
                beat_q <= beat_q + 1'b1;
            end
        end
    end

endmodule

//--- dma/operand_buffer.sv
// four-row operand store between the DMA and the matrix engine
// one write port fed from AXI read beats, one registered read row per cycle

`timescale 1ns/1ps

module operand_buffer (
    input  logic              clk,
    input  logic              rst_n,
    input  mm_pkg::buf_wr_t   wr_i,
    input  mm_pkg::row_idx_t  rd_row_i,
    output mm_pkg::row_t      rd_data_o
);

    import mm_pkg::*;

    // storage, one word per row
    row_t rows_q [SA_WIDTH];

    // write side, driven by the dma on each accepted beat
    always_ff @(posedge clk) begin
        if (wr_i.en) begin
            rows_q[wr_i.row] <= wr_i.data;
        end
    end

    // read side
    // data shows up the cycle after the row index
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_data_o <= '0;
        end else begin
            rd_data_o <= rows_q[rd_row_i];
        end
    end

endmodule

//--- common/mm_pkg.sv
// shared widths, types and AXI channel structs for the matrix-multiply accelerator
// imported by every RTL module; fixes the array at 4x4 signed 8-bit operands

package mm_pkg;

    // array geometry
    localparam int SA_WIDTH = 4;

    // fixed-point widths with a meaning of their own
    typedef logic [31:0]        addr_t;
    typedef logic [31:0]        data_t;
    typedef logic signed [7:0]  elem_t;
    // four elements, element 0 in the low byte
    typedef logic [31:0]        row_t;
    typedef logic signed [31:0] acc_t;
    typedef logic [1:0]         row_idx_t;
    typedef logic [0:0]         axi_id_t;
    typedef logic [7:0]         axi_len_t;

    // AXI ids and burst shapes
    localparam axi_id_t  ID_A           = 1'b0;
    localparam axi_id_t  ID_B           = 1'b1;
    // len is beats minus one
    localparam axi_len_t BURST_LEN_AB   = 8'd3;
    localparam axi_len_t BURST_LEN_C    = 8'd15;
    localparam logic [2:0] AXI_SIZE_4B  = 3'd2;
    localparam logic [1:0] AXI_BURST_INCR = 2'd1;

    // read address channel, master to slave
    typedef struct packed {
        logic       valid;
        axi_id_t    id;
        addr_t      addr;
        axi_len_t   len;
        logic [2:0] size;
        logic [1:0] burst;
    } axi_ar_t;

    // read data channel, slave to master
    typedef struct packed {
        logic    valid;
        axi_id_t id;
        data_t   data;
        logic    last;
    } axi_r_t;

    // write address channel
    typedef struct packed {
        logic       valid;
        addr_t      addr;
        axi_len_t   len;
        logic [2:0] size;
        logic [1:0] burst;
    } axi_aw_t;

    // write data channel
    typedef struct packed {
        logic       valid;
        data_t      data;
        logic [3:0] strb;
        logic       last;
    } axi_w_t;

    // write response channel
    typedef struct packed {
        logic       valid;
        logic [1:0] resp;
    } axi_b_t;

    // operand buffer write port
    typedef struct packed {
        logic     en;
        row_idx_t row;
        row_t     data;
    } buf_wr_t;

    // result matrix, entry i*4+j
    typedef acc_t [SA_WIDTH*SA_WIDTH-1:0] acc_mat_t;

    typedef enum logic [2:0] {
        IDLE,
        REQ_A,
        REQ_B,
        LOAD,
        COMPUTE,
        REQ_C,
        WRITE_C,
        RESP_C
    } dma_state_e;

endpackage
